// ==== source/board_test_defs.svh ====
// ------------------------------------------------
// Board self-test status hub
// Widths and counts shared by the RTL blocks
// ------------------------------------------------
`ifndef BOARD_TEST_DEFS_SVH
`define BOARD_TEST_DEFS_SVH

// XAUI ports and frame counters
`define BT_NUM_XAUI 4
`define BT_COUNT_W 16

// Aurora error count per channel
`define BT_AERR_W 8

// Link status, 4 XAUI then 2 Aurora
`define BT_LINK_W 6

// Register bus
`define BT_REG_W 32
`define BT_ADDR_W 4

// Stored control bits
`define BT_CTRL_W 9

// Version words, second one when Aurora is locked
`define BT_HW_VER_BASE 32'h0000_0100
`define BT_HW_VER_AURORA 32'h0000_0104

`endif

// ==== source/board_status_pkg.sv ====
// ------------------------------------------------
// Status hub types
// Register map, bus slave states, control bits
// ------------------------------------------------
`include "board_test_defs.svh"

package board_status_pkg;

  // Legal register addresses, status bank first
  typedef enum logic [`BT_ADDR_W-1:0] {
    XAUI_CNT0  = 4'd0,
    XAUI_CNT1  = 4'd1,
    XAUI_CNT2  = 4'd2,
    XAUI_CNT3  = 4'd3,
    XAUI_ERR01 = 4'd4,
    XAUI_ERR23 = 4'd5,
    AURORA_ERR = 4'd6,
    FLAGS      = 4'd7,
    HW_VER     = 4'd8,
    CTRL       = 4'd13
  } reg_addr_e;

  typedef enum logic {
    BUS_IDLE = 1'b0,
    BUS_RESP = 1'b1
  } bus_state_e;

  // Bit positions in the control word
  typedef enum logic [3:0] {
    PHY_RST     = 4'd0,
    XAUI_RST    = 4'd1,
    GEN_RST     = 4'd2,
    LED1        = 4'd3,
    LED2        = 4'd4,
    XAUI_OK_LSB = 4'd5
  } ctrl_bit_e;

endpackage

// ==== source/port_counters.sv ====
// ------------------------------------------------
// Frame counters for one XAUI port
// Counts tx frames, rx frames and rx errors
// ------------------------------------------------
`timescale 1ns/10ps
`include "board_test_defs.svh"

module port_counters (
  input  logic                   clk156,
  input  logic                   arst_n,
  input  logic                   cnt_clear,
  input  logic                   tx_frame,
  input  logic                   rx_frame,
  input  logic                   rx_err,
  output logic [`BT_COUNT_W-1:0] tx_count,
  output logic [`BT_COUNT_W-1:0] rx_count,
  output logic [`BT_COUNT_W-1:0] err_count
);

  // Index 0 tx, 1 rx, 2 error
  logic [2:0]                  pulse;
  logic [2:0][`BT_COUNT_W-1:0] count_q;

  assign pulse = {rx_err, rx_frame, tx_frame};

  // Wrapping counters, held at zero during clear
  always_ff @(posedge clk156 or negedge arst_n) begin
    if (!arst_n) begin
      count_q <= '0;
    end else begin
      for (int i = 0; i < 3; i++) begin
        if (cnt_clear) begin
          count_q[i] <= '0;
        end else if (pulse[i]) begin
          count_q[i] <= count_q[i] + 1'b1;
        end
      end
    end
  end

  assign tx_count  = count_q[0];
  assign rx_count  = count_q[1];
  assign err_count = count_q[2];

  // ------------------------------------------------
  // Checks
  // ------------------------------------------------
  a_clear_zero: assert property (
    @(posedge clk156) disable iff (!arst_n)
    cnt_clear |=> (tx_count == '0) && (rx_count == '0) && (err_count == '0)
  ) else $error("port counters not zero after clear");

endmodule

// ==== source/status_capture.sv ====
// ------------------------------------------------
// Status bank capture
// Packs counters and flags, two register stages
// ------------------------------------------------
`timescale 1ns/10ps
`include "board_test_defs.svh"

module status_capture (
  input  logic                                     clk156,
  input  logic                                     arst_n,
  input  logic [`BT_NUM_XAUI-1:0][`BT_COUNT_W-1:0] tx_count,
  input  logic [`BT_NUM_XAUI-1:0][`BT_COUNT_W-1:0] rx_count,
  input  logic [`BT_NUM_XAUI-1:0][`BT_COUNT_W-1:0] err_count,
  input  logic [1:0][`BT_AERR_W-1:0]               aurora_err_count,
  input  logic                                     aurora_locked,
  input  logic [`BT_LINK_W-1:0]                    link_status,
  // [0] pwr, [1] if, [2] flash
  input  logic [2:0]                               cpld_ok,
  // [0] clk25, [1] supr
  input  logic [1:0]                               clk_ok,
  input  logic [2:0]                               sram_cal_done,
  input  logic [2:0]                               sram_cmp_err,
  output logic [board_status_pkg::FLAGS:0][`BT_REG_W-1:0] status_word
);

  logic [board_status_pkg::FLAGS:0][`BT_REG_W-1:0] pack;
  logic [board_status_pkg::FLAGS:0][`BT_REG_W-1:0] stage_q;
  logic [`BT_REG_W-1:0]                            flags;

  // Flags word layout
  always_comb begin
    flags                   = '0;
    flags[`BT_LINK_W-1:0]   = link_status;
    flags[8:6]              = cpld_ok;
    flags[10:9]             = clk_ok;
    // cal_done and cmp_err interleaved per controller
    for (int c = 0; c < 3; c++) begin
      flags[11 + 2*c] = sram_cal_done[c];
      flags[12 + 2*c] = sram_cmp_err[c];
    end
    flags[17]               = aurora_locked;
  end

  always_comb begin
    pack = '0;
    // One word per port, tx above rx
    for (int p = 0; p < `BT_NUM_XAUI; p++) begin
      pack[p] = {tx_count[p], rx_count[p]};
    end
    pack[board_status_pkg::XAUI_ERR01] = {err_count[1], err_count[0]};
    pack[board_status_pkg::XAUI_ERR23] = {err_count[3], err_count[2]};
    pack[board_status_pkg::AURORA_ERR] = {8'h00, aurora_err_count[1],
                                          8'h00, aurora_err_count[0]};
    pack[board_status_pkg::FLAGS]      = flags;
  end

  // ------------------------------------------------
  // Two stage bank
  // ------------------------------------------------
  always_ff @(posedge clk156 or negedge arst_n) begin
    if (!arst_n) begin
      stage_q     <= '0;
      status_word <= '0;
    end else begin
      stage_q     <= pack;
      status_word <= stage_q;
    end
  end

endmodule

// ==== source/control_reg.sv ====
// ------------------------------------------------
// Control register
// Stores the control word, decodes board outputs
// ------------------------------------------------
`timescale 1ns/10ps
`include "board_test_defs.svh"

module control_reg (
  input  logic                    clk156,
  input  logic                    arst_n,
  input  logic                    ctrl_we,
  input  logic [`BT_CTRL_W-1:0]   ctrl_wdata,
  output logic [`BT_CTRL_W-1:0]   ctrl_word,
  output logic                    led1,
  output logic                    led2,
  output logic                    phy_rst_n,
  output logic                    xaui_reset,
  output logic                    xgmii_gen_reset,
  output logic [`BT_NUM_XAUI-1:0] xaui_ok
);

  always_ff @(posedge clk156 or negedge arst_n) begin
    if (!arst_n) begin
      ctrl_word <= '0;
    end else if (ctrl_we) begin
      ctrl_word <= ctrl_wdata;
    end
  end

  // Decoded outputs lag the stored word by one cycle
  always_ff @(posedge clk156 or negedge arst_n) begin
    if (!arst_n) begin
      phy_rst_n       <= 1'b1;
      xaui_reset      <= 1'b0;
      xgmii_gen_reset <= 1'b0;
      led1            <= 1'b0;
      led2            <= 1'b0;
      xaui_ok         <= '0;
    end else begin
      phy_rst_n       <= ~ctrl_word[board_status_pkg::PHY_RST];
      xaui_reset      <= ctrl_word[board_status_pkg::XAUI_RST];
      xgmii_gen_reset <= ctrl_word[board_status_pkg::GEN_RST];
      led1            <= ctrl_word[board_status_pkg::LED1];
      led2            <= ctrl_word[board_status_pkg::LED2];
      xaui_ok         <= ctrl_word[board_status_pkg::XAUI_OK_LSB +: `BT_NUM_XAUI];
    end
  end

endmodule

// ==== source/reg_access.sv ====
// ------------------------------------------------
// Register bus slave
// Valid/ready requests, one response outstanding
// ------------------------------------------------
`timescale 1ns/10ps
`include "board_test_defs.svh"

module reg_access (
  input  logic                  clk156,
  input  logic                  arst_n,
  // Request channel
  input  logic                  req_valid,
  output logic                  req_ready,
  input  logic                  req_write,
  input  logic [`BT_ADDR_W-1:0] req_addr,
  input  logic [`BT_REG_W-1:0]  req_wdata,
  // Response channel
  output logic                  rsp_valid,
  input  logic                  rsp_ready,
  output logic [`BT_REG_W-1:0]  rsp_rdata,
  output logic                  rsp_err,
  // Register sources
  input  logic [board_status_pkg::FLAGS:0][`BT_REG_W-1:0] status_word,
  input  logic                  aurora_locked,
  input  logic [`BT_CTRL_W-1:0] ctrl_word,
  output logic                  ctrl_we,
  output logic [`BT_CTRL_W-1:0] ctrl_wdata
);

  board_status_pkg::bus_state_e state_q;
  board_status_pkg::reg_addr_e  addr;
  logic                         accept;
  logic [`BT_REG_W-1:0]         rdata_d;
  logic                         err_d;

  assign req_ready = (state_q == board_status_pkg::BUS_IDLE);
  assign rsp_valid = (state_q == board_status_pkg::BUS_RESP);
  assign accept    = req_valid && req_ready;
  assign addr      = board_status_pkg::reg_addr_e'(req_addr);

  assign ctrl_we    = accept && req_write && (addr == board_status_pkg::CTRL);
  assign ctrl_wdata = req_wdata[`BT_CTRL_W-1:0];

  // ------------------------------------------------
  // Read mux and address check
  // ------------------------------------------------
  always_comb begin
    rdata_d = '0;
    err_d   = 1'b0;
    case (addr)
      board_status_pkg::XAUI_CNT0,
      board_status_pkg::XAUI_CNT1,
      board_status_pkg::XAUI_CNT2,
      board_status_pkg::XAUI_CNT3,
      board_status_pkg::XAUI_ERR01,
      board_status_pkg::XAUI_ERR23,
      board_status_pkg::AURORA_ERR,
      board_status_pkg::FLAGS: rdata_d = status_word[req_addr[2:0]];
      board_status_pkg::HW_VER:
        rdata_d = aurora_locked ? `BT_HW_VER_AURORA : `BT_HW_VER_BASE;
      board_status_pkg::CTRL:
        rdata_d = {{(`BT_REG_W-`BT_CTRL_W){1'b0}}, ctrl_word};
      default: err_d = 1'b1;
    endcase
    // Writes return no data
    if (req_write) begin
      rdata_d = '0;
    end
  end

  always_ff @(posedge clk156 or negedge arst_n) begin
    if (!arst_n) begin
      state_q   <= board_status_pkg::BUS_IDLE;
      rsp_rdata <= '0;
      rsp_err   <= 1'b0;
    end else begin
      case (state_q)
        board_status_pkg::BUS_IDLE: begin
          if (accept) begin
            rsp_rdata <= rdata_d;
            rsp_err   <= err_d;
            state_q   <= board_status_pkg::BUS_RESP;
          end
        end
        default: begin
          // Hold the response until it is taken
          if (rsp_ready) begin
            state_q <= board_status_pkg::BUS_IDLE;
          end
        end
      endcase
    end
  end

  // ------------------------------------------------
  // Checks
  // ------------------------------------------------
  a_rsp_hold: assert property (
    @(posedge clk156) disable iff (!arst_n)
    (rsp_valid && !rsp_ready) |=> rsp_valid && $stable(rsp_rdata) && $stable(rsp_err)
  ) else $error("response changed before rsp_ready");

endmodule

// ==== source/board_status_top.sv ====
// ------------------------------------------------
// Board status hub top level
// Counters, status bank, control and register bus
// ------------------------------------------------
`timescale 1ns/10ps
`include "board_test_defs.svh"

module board_status_top (
  input  logic                    clk156,
  input  logic                    arst_n,
  // Register bus
  input  logic                    req_valid,
  output logic                    req_ready,
  input  logic                    req_write,
  input  logic [`BT_ADDR_W-1:0]   req_addr,
  input  logic [`BT_REG_W-1:0]    req_wdata,
  output logic                    rsp_valid,
  input  logic                    rsp_ready,
  output logic [`BT_REG_W-1:0]    rsp_rdata,
  output logic                    rsp_err,
  // Frame events per XAUI port
  input  logic [`BT_NUM_XAUI-1:0] tx_frame,
  input  logic [`BT_NUM_XAUI-1:0] rx_frame,
  input  logic [`BT_NUM_XAUI-1:0] rx_err,
  // Aurora and board flags
  input  logic [1:0][`BT_AERR_W-1:0] aurora_err_count,
  input  logic                    aurora_locked,
  input  logic [`BT_LINK_W-1:0]   link_status,
  input  logic [2:0]              cpld_ok,
  input  logic [1:0]              clk_ok,
  input  logic [2:0]              sram_cal_done,
  input  logic [2:0]              sram_cmp_err,
  // Board outputs
  output logic                    led1,
  output logic                    led2,
  output logic                    phy_rst_n,
  output logic                    xaui_reset,
  output logic                    xgmii_gen_reset,
  output logic [`BT_NUM_XAUI-1:0] xaui_ok
);

  logic [`BT_NUM_XAUI-1:0][`BT_COUNT_W-1:0]        tx_count;
  logic [`BT_NUM_XAUI-1:0][`BT_COUNT_W-1:0]        rx_count;
  logic [`BT_NUM_XAUI-1:0][`BT_COUNT_W-1:0]        err_count;
  logic [board_status_pkg::FLAGS:0][`BT_REG_W-1:0] status_word;
  logic [`BT_CTRL_W-1:0]                           ctrl_word;
  logic [`BT_CTRL_W-1:0]                           ctrl_wdata;
  logic                                            ctrl_we;

  // Counter clear follows the decoded generator reset
  for (genvar g = 0; g < `BT_NUM_XAUI; g++) begin : g_port
    port_counters u_port_counters (
      .clk156    (clk156),
      .arst_n    (arst_n),
      .cnt_clear (xgmii_gen_reset),
      .tx_frame  (tx_frame[g]),
      .rx_frame  (rx_frame[g]),
      .rx_err    (rx_err[g]),
      .tx_count  (tx_count[g]),
      .rx_count  (rx_count[g]),
      .err_count (err_count[g])
    );
  end

  status_capture u_status_capture (
    .clk156           (clk156),
    .arst_n           (arst_n),
    .tx_count         (tx_count),
    .rx_count         (rx_count),
    .err_count        (err_count),
    .aurora_err_count (aurora_err_count),
    .aurora_locked    (aurora_locked),
    .link_status      (link_status),
    .cpld_ok          (cpld_ok),
    .clk_ok           (clk_ok),
    .sram_cal_done    (sram_cal_done),
    .sram_cmp_err     (sram_cmp_err),
    .status_word      (status_word)
  );

  control_reg u_control_reg (
    .clk156          (clk156),
    .arst_n          (arst_n),
    .ctrl_we         (ctrl_we),
    .ctrl_wdata      (ctrl_wdata),
    .ctrl_word       (ctrl_word),
    .led1            (led1),
    .led2            (led2),
    .phy_rst_n       (phy_rst_n),
    .xaui_reset      (xaui_reset),
    .xgmii_gen_reset (xgmii_gen_reset),
    .xaui_ok         (xaui_ok)
  );

  reg_access u_reg_access (
    .clk156        (clk156),
    .arst_n        (arst_n),
    .req_valid     (req_valid),
    .req_ready     (req_ready),
    .req_write     (req_write),
    .req_addr      (req_addr),
    .req_wdata     (req_wdata),
    .rsp_valid     (rsp_valid),
    .rsp_ready     (rsp_ready),
    .rsp_rdata     (rsp_rdata),
    .rsp_err       (rsp_err),
    .status_word   (status_word),
    .aurora_locked (aurora_locked),
    .ctrl_word     (ctrl_word),
    .ctrl_we       (ctrl_we),
    .ctrl_wdata    (ctrl_wdata)
  );

endmodule

// ==== tb/tb_board_status.sv ====
// ------------------------------------------------
// Testbench for the board status hub
// Table-driven bus transactions against a model
// ------------------------------------------------
`timescale 1ns/10ps
`include "board_test_defs.svh"

module tb_board_status;

  localparam int NUM_ROWS   = 28;
  localparam int MAX_CYCLES = 64 * NUM_ROWS + 200;
  // Delay code for a random rsp_ready delay
  localparam logic [3:0] RND = 4'hf;

  // pulses [2] tx, [1] rx, [0] error, then port, then count
  // bd is {aurora_locked, link_status, cpld_ok, clk_ok, sram_cal_done, sram_cmp_err}
  typedef struct packed {
    logic [2:0][3:0][3:0] pulses;
    logic [15:0]          aur;
    logic [17:0]          bd;
    logic                 write;
    logic [3:0]           addr;
    logic [31:0]          wdata;
    logic                 use_model;
    logic [31:0]          exp_rdata;
    logic                 exp_err;
    logic [3:0]           delay;
  } row_t;

  logic clk156 = 1'b0;
  logic arst_n;
  logic req_valid, req_ready, req_write, rsp_valid, rsp_ready, rsp_err;
  logic [`BT_ADDR_W-1:0] req_addr;
  logic [`BT_REG_W-1:0] req_wdata, rsp_rdata;
  logic [`BT_NUM_XAUI-1:0] tx_frame, rx_frame, rx_err, xaui_ok;
  logic [1:0][`BT_AERR_W-1:0] aurora_err_count;
  logic aurora_locked, led1, led2, phy_rst_n, xaui_reset, xgmii_gen_reset;
  logic [`BT_LINK_W-1:0] link_status;
  logic [2:0] cpld_ok, sram_cal_done, sram_cmp_err;
  logic [1:0] clk_ok;

  // Reference model state, indexed by port
  logic [3:0][15:0] m_tx, m_rx, m_err;
  logic [8:0]       m_ctrl;
  row_t             rows [NUM_ROWS];
  integer           seed = 32'ha6300c33;
  int               cycle_count = 0;

  board_status_top dut0 (.*);

  always #2 clk156 = ~clk156;

  always @(posedge clk156) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: test did not finish within %0d cycles", MAX_CYCLES);
      $display("Verification failed");
      $fatal(1);
    end
  end

  task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
    if (actual !== expected) begin
      $display("** Error at %0t: %s is %h, expected %h", $time, what, actual, expected);
      $display("Verification failed");
      $fatal(1);
    end
  endtask

  // ------------------------------------------------
  // Reference model
  // ------------------------------------------------
  function automatic logic [31:0] model_word(input logic [3:0] a);
    logic [31:0] w;
    w = 32'h0;
    case (a)
      4'd0, 4'd1, 4'd2, 4'd3: w = {m_tx[a[1:0]], m_rx[a[1:0]]};
      4'd4: w = {m_err[1], m_err[0]};
      4'd5: w = {m_err[3], m_err[2]};
      4'd6: w = {8'h00, aurora_err_count[1], 8'h00, aurora_err_count[0]};
      4'd7: w = {14'h0, aurora_locked, sram_cmp_err[2], sram_cal_done[2],
                 sram_cmp_err[1], sram_cal_done[1], sram_cmp_err[0], sram_cal_done[0],
                 clk_ok, cpld_ok, link_status};
      default: w = 32'h0;
    endcase
    return w;
  endfunction

  // Control write taken by the model, GEN_RST zeroes the counts
  task automatic apply_ctrl_write(input logic [31:0] wdata);
    m_ctrl = wdata[8:0];
    if (m_ctrl[2]) begin
      m_tx  = '0;
      m_rx  = '0;
      m_err = '0;
    end
  endtask

  task automatic check_outputs;
    compare({31'h0, phy_rst_n}, {31'h0, ~m_ctrl[0]}, "phy_rst_n");
    compare({31'h0, xaui_reset}, {31'h0, m_ctrl[1]}, "xaui_reset");
    compare({31'h0, xgmii_gen_reset}, {31'h0, m_ctrl[2]}, "xgmii_gen_reset");
    compare({31'h0, led1}, {31'h0, m_ctrl[3]}, "led1");
    compare({31'h0, led2}, {31'h0, m_ctrl[4]}, "led2");
    compare({28'h0, xaui_ok}, {28'h0, m_ctrl[8:5]}, "xaui_ok");
  endtask

  // Pulse counts up to 15 per port, then accumulate in the model
  task automatic drive_pulses(input row_t r);
    logic [3:0] tx_v;
    logic [3:0] rx_v;
    logic [3:0] err_v;
    for (int k = 0; k < 15; k++) begin
      for (int p = 0; p < 4; p++) begin
        tx_v[p]  = int'(r.pulses[2][p]) > k;
        rx_v[p]  = int'(r.pulses[1][p]) > k;
        err_v[p] = int'(r.pulses[0][p]) > k;
      end
      @(posedge clk156);
      tx_frame <= tx_v;
      rx_frame <= rx_v;
      rx_err   <= err_v;
    end
    @(posedge clk156);
    tx_frame <= '0;
    rx_frame <= '0;
    rx_err   <= '0;
    if (!m_ctrl[2]) begin
      for (int p = 0; p < 4; p++) begin
        m_tx[p]  = m_tx[p] + {12'h0, r.pulses[2][p]};
        m_rx[p]  = m_rx[p] + {12'h0, r.pulses[1][p]};
        m_err[p] = m_err[p] + {12'h0, r.pulses[0][p]};
      end
    end
  endtask

  task automatic check_held(input logic [31:0] rdata, input logic err);
    compare({31'h0, rsp_valid}, 32'h1, "rsp_valid while pending");
    compare(rsp_rdata, rdata, "rsp_rdata while pending");
    compare({31'h0, rsp_err}, {31'h0, err}, "rsp_err while pending");
    compare({31'h0, req_ready}, 32'h0, "req_ready while pending");
  endtask

  task automatic bus_transfer(input logic write, input logic [3:0] addr,
                              input logic [31:0] wdata, input int delay,
                              output logic [31:0] rdata, output logic err);
    @(posedge clk156);
    req_valid <= 1'b1;
    req_write <= write;
    req_addr  <= addr;
    req_wdata <= wdata;
    @(negedge clk156);
    while (!req_ready) @(negedge clk156);
    @(posedge clk156);
    req_valid <= 1'b0;
    // Response due one cycle after acceptance, board outputs one cycle later
    @(negedge clk156);
    rdata = rsp_rdata;
    err   = rsp_err;
    check_held(rdata, err);
    check_outputs();
    if (write && addr == 4'd13) begin
      apply_ctrl_write(wdata);
    end
    @(negedge clk156);
    check_held(rdata, err);
    check_outputs();
    repeat (delay) begin
      @(negedge clk156);
      check_held(rdata, err);
    end
    @(posedge clk156);
    rsp_ready <= 1'b1;
    @(negedge clk156);
    check_held(rdata, err);
    @(posedge clk156);
    rsp_ready <= 1'b0;
    @(negedge clk156);
    compare({31'h0, rsp_valid}, 32'h0, "rsp_valid after transfer");
    compare({31'h0, req_ready}, 32'h1, "req_ready after transfer");
  endtask

  // ------------------------------------------------
  // Stimulus table
  // ------------------------------------------------
  function automatic void fill_rows;
    rows[0]  = '{48'h0, 16'h0, 18'h0, 1'b0, 4'd13, 32'h0, 1'b0, 32'h0, 1'b0, 4'd0};
    rows[1]  = '{48'h4321_1357_0213, 16'h0, 18'h0, 1'b0, 4'd0, 32'h0, 1'b1, 32'h0, 1'b0, 4'd0};
    rows[2]  = '{48'h0, 16'h0, 18'h0, 1'b0, 4'd1, 32'h0, 1'b1, 32'h0, 1'b0, 4'd2};
    rows[3]  = '{48'h0, 16'h0, 18'h0, 1'b0, 4'd2, 32'h0, 1'b1, 32'h0, 1'b0, RND};
    rows[4]  = '{48'h0, 16'h0, 18'h0, 1'b0, 4'd3, 32'h0, 1'b1, 32'h0, 1'b0, RND};
    rows[5]  = '{48'h9A5C_0F3E_7D21, 16'h0, 18'h0, 1'b0, 4'd4, 32'h0, 1'b1, 32'h0, 1'b0, 4'd1};
    rows[6]  = '{48'h0, 16'h0, 18'h0, 1'b0, 4'd5, 32'h0, 1'b1, 32'h0, 1'b0, 4'd0};
    rows[7]  = '{48'h0, 16'hA55A, 18'h16D9E, 1'b0, 4'd6, 32'h0, 1'b1, 32'h0, 1'b0, 4'd0};
    rows[8]  = '{48'h0, 16'hA55A, 18'h16D9E, 1'b0, 4'd7, 32'h0, 1'b1, 32'h0, 1'b0, RND};
    rows[9]  = '{48'h0, 16'hA55A, 18'h16D9E, 1'b0, 4'd8, 32'h0, 1'b0, 32'h100, 1'b0, 4'd0};
    rows[10] = '{48'h0, 16'hA55A, 18'h36D9E, 1'b0, 4'd8, 32'h0, 1'b0, 32'h104, 1'b0, RND};
    rows[11] = '{48'h0, 16'h7E81, 18'h29261, 1'b0, 4'd7, 32'h0, 1'b1, 32'h0, 1'b0, 4'd3};
    rows[12] = '{48'h0, 16'h7E81, 18'h29261, 1'b0, 4'd6, 32'h0, 1'b1, 32'h0, 1'b0, 4'd0};
    // Write outside CTRL has no effect
    rows[13] = '{48'h0, 16'h0, 18'h0, 1'b1, 4'd0, 32'hFFFF_FFFF, 1'b0, 32'h0, 1'b0, RND};
    rows[14] = '{48'h0, 16'h0, 18'h0, 1'b1, 4'd13, 32'hABCD_EE1B, 1'b0, 32'h0, 1'b0, 4'd0};
    rows[15] = '{48'h0, 16'h0, 18'h0, 1'b0, 4'd13, 32'h0, 1'b0, 32'h1B, 1'b0, RND};
    // Counter clear on, then off again
    rows[16] = '{48'h0, 16'h0, 18'h0, 1'b1, 4'd13, 32'h0000_01E4, 1'b0, 32'h0, 1'b0, 4'd2};
    rows[17] = '{48'h1111_2222_3333, 16'h0, 18'h0, 1'b0, 4'd0, 32'h0, 1'b1, 32'h0, 1'b0, RND};
    rows[18] = '{48'h0, 16'h0, 18'h0, 1'b0, 4'd5, 32'h0, 1'b1, 32'h0, 1'b0, 4'd0};
    rows[19] = '{48'h0, 16'h0, 18'h0, 1'b1, 4'd13, 32'h0000_0060, 1'b0, 32'h0, 1'b0, 4'd0};
    rows[20] = '{48'h2F01_1234_0505, 16'h0, 18'h0, 1'b0, 4'd1, 32'h0, 1'b1, 32'h0, 1'b0, RND};
    rows[21] = '{48'h0, 16'h0, 18'h0, 1'b0, 4'd9, 32'h0, 1'b0, 32'h0, 1'b1, 4'd0};
    rows[22] = '{48'h0, 16'h0, 18'h0, 1'b0, 4'd10, 32'h0, 1'b0, 32'h0, 1'b1, RND};
    rows[23] = '{48'h0, 16'h0, 18'h0, 1'b0, 4'd11, 32'h0, 1'b0, 32'h0, 1'b1, 4'd1};
    rows[24] = '{48'h0, 16'h0, 18'h0, 1'b0, 4'd12, 32'h0, 1'b0, 32'h0, 1'b1, RND};
    rows[25] = '{48'h0, 16'h0, 18'h0, 1'b0, 4'd14, 32'h0, 1'b0, 32'h0, 1'b1, 4'd0};
    rows[26] = '{48'h0, 16'h0, 18'h0, 1'b0, 4'd15, 32'h0, 1'b0, 32'h0, 1'b1, RND};
    rows[27] = '{48'h0, 16'h0, 18'h0, 1'b0, 4'd13, 32'h0, 1'b0, 32'h60, 1'b0, RND};
  endfunction

  initial begin
    row_t        r;
    logic [31:0] rdata;
    logic [31:0] expected;
    logic        err;
    int          delay;
    arst_n           = 1'b0;
    req_valid        = 1'b0;
    req_write        = 1'b0;
    req_addr         = '0;
    req_wdata        = '0;
    rsp_ready        = 1'b0;
    tx_frame         = '0;
    rx_frame         = '0;
    rx_err           = '0;
    aurora_err_count = '0;
    {aurora_locked, link_status, cpld_ok, clk_ok, sram_cal_done, sram_cmp_err} = '0;
    m_tx   = '0;
    m_rx   = '0;
    m_err  = '0;
    m_ctrl = '0;
    fill_rows();
    repeat (16) @(posedge clk156);
    arst_n <= 1'b1;
    repeat (2) @(posedge clk156);
    @(negedge clk156);
    compare({31'h0, req_ready}, 32'h1, "req_ready after reset");
    compare({31'h0, rsp_valid}, 32'h0, "rsp_valid after reset");
    check_outputs();

    for (int i = 0; i < NUM_ROWS; i++) begin
      r = rows[i];
      @(posedge clk156);
      aurora_err_count <= r.aur;
      {aurora_locked, link_status, cpld_ok, clk_ok, sram_cal_done, sram_cmp_err} <= r.bd;
      drive_pulses(r);
      // Bank needs three cycles to show a count
      repeat (4) @(posedge clk156);
      delay = (r.delay == RND) ? int'($unsigned($random(seed)) % 6) : int'(r.delay);
      expected = r.use_model ? model_word(r.addr) : r.exp_rdata;
      bus_transfer(r.write, r.addr, r.wdata, delay, rdata, err);
      compare(rdata, expected, $sformatf("rsp_rdata of row %0d", i));
      compare({31'h0, err}, {31'h0, r.exp_err}, $sformatf("rsp_err of row %0d", i));
      repeat (2) @(posedge clk156);
      @(negedge clk156);
      check_outputs();
    end

    $display("Verification passed");
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+source
source/board_status_pkg.sv
source/port_counters.sv
source/status_capture.sv
source/control_reg.sv
source/reg_access.sv
source/board_status_top.sv
tb/tb_board_status.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile the status hub testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_board_status -f src.f -o tb_board_status_sim

./obj_dir/tb_board_status_sim | tee sim.log

if grep -qx "Verification passed" sim.log; then
  echo "Simulation PASSED"
else
  echo "Simulation FAILED"
  exit 1
fi
